// File: bench/main_ram_model.sv
/*
 * Behavioral 16-bit main RAM with random ok stalls
 * Even byte on the upper lane, keeps a record of byte writes
 */
`timescale 1ns/1ps
`default_nettype none

module main_ram_model (
    input  logic                     clk,
    input  mcu_link_pkg::word_addr_t addr_i,
    input  logic                     ds_i,
    input  logic                     wr_i,
    input  logic                     acc_i,
    input  mcu_link_pkg::data8_t     wdata_i,
    output mcu_link_pkg::data16_t    rdata_o,
    output logic                     ok_o
);
    import mcu_link_pkg::*;

    data16_t    mem [0:32767];
    integer     seed;
    logic [1:0] stall;
    int         wr_count = 0;
    byte_addr_t last_addr;
    data8_t     last_data;

    // Random contents, fixed seed
    initial begin
        seed = 32'h5e96b5be;
        for (int i = 0; i < 32768; i++) begin
            mem[i] = 16'($random(seed));
        end
    end

    // Stall length drawn while idle, counted down during the access
    always @(posedge clk) begin
        if (!acc_i) begin
            stall <= 2'($random(seed));
        end else if (stall != 2'd0) begin
            stall <= stall - 2'd1;
        end
    end

    assign ok_o    = acc_i && (stall == 2'd0);
    assign rdata_o = mem[addr_i];

    // Byte write into one lane
    always @(posedge clk) begin
        if (acc_i && ok_o && wr_i) begin
            if (ds_i) begin
                mem[addr_i][7:0] <= wdata_i;
            end else begin
                mem[addr_i][15:8] <= wdata_i;
            end
            wr_count  <= wr_count + 1;
            last_addr <= {addr_i, ds_i};
            last_data <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: bench/mcu_link_tb.sv
/*
 * Testbench for the checksum coprocessor
 * APB setup, DMA edge trigger, RAM model with stalls, reference checksum
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_link_tb;
    import mcu_link_pkg::*;

    localparam int NUM_JOBS  = 6;
    localparam int MAX_LEN   = 255;
    localparam int WD_CYCLES = NUM_JOBS * (MAX_LEN + 1) * (CEN_PERIOD + 4) + 2000;

    logic       clk = 1'b0;
    logic       rst_cpu;
    apb_req_t   apb;
    apb_rsp_t   apb_rsp;
    logic       dma_on_n;
    logic       bus_req_n;
    word_addr_t ram_addr;
    logic       ram_ds;
    logic       ram_wr;
    logic       ram_acc;
    data8_t     ram_dout;
    data16_t    ram_din;
    logic       ram_ok;

    // Expected write per job, {byte address, checksum}
    logic [23:0] exp_q[$];
    logic [23:0] exp_item;
    logic        bus_prev = 1'b1;

    always #4 clk = ~clk;

    mcu_link_top dut0 (
        .clk         (clk),
        .rst_cpu     (rst_cpu),
        .apb_i       (apb),
        .apb_o       (apb_rsp),
        .dma_on_n_i  (dma_on_n),
        .bus_req_n_o (bus_req_n),
        .ram_addr_o  (ram_addr),
        .ram_ds_o    (ram_ds),
        .ram_wr_o    (ram_wr),
        .ram_acc_o   (ram_acc),
        .ram_dout_o  (ram_dout),
        .ram_din_i   (ram_din),
        .ram_ok_i    (ram_ok)
    );

    main_ram_model ram0 (
        .clk     (clk),
        .addr_i  (ram_addr),
        .ds_i    (ram_ds),
        .wr_i    (ram_wr),
        .acc_i   (ram_acc),
        .wdata_i (ram_dout),
        .rdata_o (ram_din),
        .ok_o    (ram_ok)
    );

    task automatic fail_now(input string why);
        $display("%s at %0t", why, $time);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            fail_now("Check failed");
        end
    endtask

    // Even byte address is the upper half of the word
    function automatic data8_t read_byte(input byte_addr_t a);
        data16_t w;
        w = ram0.mem[a[15:1]];
        return a[0] ? w[7:0] : w[15:8];
    endfunction

    function automatic data8_t ref_checksum(input byte_addr_t base, input len_t len);
        data8_t sum;
        sum = 8'd0;
        for (int i = 0; i < int'(len); i++) begin
            sum = data8_t'(sum + read_byte(byte_addr_t'(base + 16'(i))));
        end
        return sum;
    endfunction

    // One APB transfer, sampled mid access phase
    task automatic apb_access(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value("pready", 32'd1, 32'(apb_rsp.pready));
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr on write", 32'd0, 32'(err));
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value("pslverr on read", 32'd0, 32'(err));
    endtask

    // End of the main CPU DMA phase
    task automatic pulse_dma;
        @(posedge clk);
        dma_on_n <= 1'b0;
        repeat (3) @(posedge clk);
        dma_on_n <= 1'b1;
    endtask

    task automatic run_job(input byte_addr_t base, input len_t len, input logic poke);
        data8_t      exp;
        byte_addr_t  wr_addr;
        logic [31:0] rd;
        int          wr_before;
        exp     = ref_checksum(base, len);
        wr_addr = byte_addr_t'(base + 16'(len));
        apb_write(REG_BASE, 32'(base));
        apb_write(REG_LEN, 32'(len));
        apb_read(REG_BASE, rd);
        check_value("BASE readback", 32'(base), rd);
        apb_read(REG_LEN, rd);
        check_value("LEN readback", 32'(len), rd);
        exp_q.push_back({wr_addr, exp});
        wr_before = ram0.wr_count;
        pulse_dma();
        do begin
            @(negedge clk);
        end while (bus_req_n);
        // Config lock and a second edge, both while busy
        if (poke) begin
            apb_write(REG_BASE, 32'h0000_7f00);
            apb_read(REG_BASE, rd);
            check_value("BASE while busy", 32'(base), rd);
            pulse_dma();
        end
        rd = '0;
        while (rd[1] == 1'b0) begin
            apb_read(REG_STATUS, rd);
        end
        check_value("STATUS at done", 32'h2, rd);
        @(negedge clk);
        check_value("bus_req_n_o after done", 32'd1, 32'(bus_req_n));
        apb_read(REG_RESULT, rd);
        check_value("RESULT", 32'(exp), rd);
        check_value("RAM write count", 32'(wr_before + 1), 32'(ram0.wr_count));
        check_value("last write address", 32'(wr_addr), 32'(ram0.last_addr));
        check_value("last write data", 32'(exp), 32'(ram0.last_data));
        check_value("byte at BASE+LEN", 32'(exp), 32'(read_byte(wr_addr)));
        apb_write(REG_STATUS, 32'h2);
        apb_read(REG_STATUS, rd);
        check_value("STATUS after clear", 32'd0, rd);
        // No job from a dropped edge
        repeat (24) @(posedge clk);
        @(negedge clk);
        check_value("bus_req_n_o idle", 32'd1, 32'(bus_req_n));
        check_value("RAM write count idle", 32'(wr_before + 1), 32'(ram0.wr_count));
    endtask

    // Bus ownership and checksum write compare
    always @(negedge clk) begin
        if (!rst_cpu) begin
            if (ram_acc && bus_req_n) begin
                fail_now("RAM access while the bus request is released");
            end
            if (ram_acc && ram_wr && ram_ok) begin
                if (exp_q.size() == 0) begin
                    fail_now("RAM write with no job pending");
                end else begin
                    exp_item = exp_q.pop_front();
                    check_value("write address", 32'(exp_item[23:8]), 32'({ram_addr, ram_ds}));
                    check_value("ram_dout_o", 32'(exp_item[7:0]), 32'(ram_dout));
                end
            end
            if (!bus_prev && bus_req_n) begin
                check_value("writes pending at bus release", 32'd0, 32'(exp_q.size()));
            end
            bus_prev = bus_req_n;
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        fail_now("Timeout, jobs did not finish in the allowed cycles");
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        rst_cpu  = 1'b1;
        apb      = '0;
        dma_on_n = 1'b1;
        repeat (2) @(posedge clk);
        rst_cpu <= 1'b0;
        @(negedge clk);
        check_value("bus_req_n_o after reset", 32'd1, 32'(bus_req_n));
        check_value("ram_acc_o after reset", 32'd0, 32'(ram_acc));
        check_value("ram_wr_o after reset", 32'd0, 32'(ram_wr));
        apb_read(REG_STATUS, rd);
        check_value("STATUS after reset", 32'd0, rd);
        // Register readback and unmapped offsets
        apb_write(REG_BASE, 32'h0000_1234);
        apb_write(REG_LEN, 32'h0000_0021);
        apb_read(REG_BASE, rd);
        check_value("BASE readback", 32'h1234, rd);
        apb_read(REG_LEN, rd);
        check_value("LEN readback", 32'h21, rd);
        apb_access(1'b0, apb_addr_t'(4'h2), 32'd0, rd, err);
        check_value("pslverr unmapped read", 32'd1, 32'(err));
        apb_access(1'b1, apb_addr_t'(4'he), 32'h0000_5555, rd, err);
        check_value("pslverr unmapped write", 32'd1, 32'(err));
        apb_read(REG_BASE, rd);
        check_value("BASE after unmapped write", 32'h1234, rd);
        // Odd and even bases, lengths 1, 2 and 255
        run_job(16'h0100, 8'd1, 1'b0);
        run_job(16'h0211, 8'd1, 1'b0);
        run_job(16'h0400, 8'd2, 1'b0);
        run_job(16'h0503, 8'd2, 1'b0);
        run_job(16'h0600, 8'd255, 1'b1);
        run_job(16'h0801, 8'd255, 1'b0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/mcu_link_pkg.sv
logic/cen_divider.sv
logic/dma_edge_irq.sv
logic/byte_lane_port.sv
logic/link_ctrl.sv
logic/mcu_link_top.sv
bench/main_ram_model.sv
bench/mcu_link_tb.sv

// File: logic/byte_lane_port.sv
/*
 * Byte view of the 16-bit main RAM bus
 * One byte access at a time, lane picked by address bit 0, waits for ram_ok
 */
`timescale 1ns/1ps
`default_nettype none

module byte_lane_port (
    input  logic                  clk,
    input  logic                  rst_cpu,
    input  mcu_link_pkg::mem_req_t req_i,
    output mcu_link_pkg::mem_rsp_t rsp_o,
    output mcu_link_pkg::word_addr_t ram_addr_o,
    output logic                  ram_ds_o,
    output logic                  ram_wr_o,
    output logic                  ram_acc_o,
    output mcu_link_pkg::data8_t   ram_dout_o,
    input  mcu_link_pkg::data16_t  ram_din_i,
    input  logic                  ram_ok_i
);
    import mcu_link_pkg::*;

    byte_addr_t addr_q;
    data8_t     wdata_q;
    data8_t     rdata_q;
    logic       done_q;
    logic       accept;

    // Idle and not in the response cycle
    assign accept = req_i.acc && !ram_acc_o && !done_q;

    // Bus control
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            ram_acc_o <= 1'b0;
            ram_wr_o  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                ram_acc_o <= 1'b1;
                ram_wr_o  <= req_i.wr;
            end else if (ram_acc_o && ram_ok_i) begin
                ram_acc_o <= 1'b0;
                ram_wr_o  <= 1'b0;
                done_q    <= 1'b1;
            end
        end
    end

    // Access payload, loaded once per accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
        end
        // Even byte sits on the upper lane
        if (ram_acc_o && ram_ok_i) begin
            rdata_q <= addr_q[0] ? ram_din_i[7:0] : ram_din_i[15:8];
        end
    end

    assign ram_addr_o = addr_q[15:1];
    assign ram_ds_o   = addr_q[0];
    assign ram_dout_o = wdata_q;
    assign rsp_o      = '{done: done_q, rdata: rdata_q};

    // Address must hold through RAM stalls
    a_addr_stable: assert property (@(posedge clk) disable iff (rst_cpu)
        (ram_acc_o && !ram_ok_i) |=> $stable(ram_addr_o));

endmodule

`default_nettype wire

// File: logic/cen_divider.sv
/*
 * Access clock enable, one pulse every CEN_PERIOD clocks
 */
`timescale 1ns/1ps
`default_nettype none

module cen_divider (
    input  logic clk,
    input  logic rst_cpu,
    output logic cen_o
);
    import mcu_link_pkg::*;

    logic [CEN_CNT_W-1:0] cnt;

    // Free running, wraps at CEN_PERIOD-1
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            cnt   <= '0;
            cen_o <= 1'b0;
        end else if (cnt == CEN_CNT_W'(CEN_PERIOD - 1)) begin
            cnt   <= '0;
            cen_o <= 1'b1;
        end else begin
            cnt   <= cnt + 1'b1;
            cen_o <= 1'b0;
        end
    end

    // Enable must stay a single-cycle strobe
    a_cen_pulse: assert property (@(posedge clk) disable iff (rst_cpu) cen_o |=> !cen_o);

endmodule

`default_nettype wire

// File: logic/dma_edge_irq.sv
/*
 * Job request latch on the end of the main CPU DMA phase
 * Synchronizes dma_on_n, catches its rising edge, holds until cleared
 */
`timescale 1ns/1ps
`default_nettype none

module dma_edge_irq (
    input  logic clk,
    input  logic rst_cpu,
    input  logic dma_on_n_i,
    input  logic busy_i,
    input  logic job_clr_i,
    output logic job_req_o
);
    logic dma_s1;
    logic dma_s2;
    logic dma_last;
    logic dma_rise;

    // DMA off is the idle level, so no false edge out of reset
    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            dma_s1   <= 1'b1;
            dma_s2   <= 1'b1;
            dma_last <= 1'b1;
        end else begin
            dma_s1   <= dma_on_n_i;
            dma_s2   <= dma_s1;
            dma_last <= dma_s2;
        end
    end

    // Main CPU leaves its DMA phase
    assign dma_rise = dma_s2 && !dma_last;

    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            job_req_o <= 1'b0;
        end else if (job_clr_i) begin
            // Clear wins over a new edge
            job_req_o <= 1'b0;
        end else if (dma_rise && !busy_i) begin
            job_req_o <= 1'b1;
        end
    end

    // Edges during a running job are dropped
    a_no_req_busy: assert property (@(posedge clk) disable iff (rst_cpu)
        $rose(job_req_o) |-> !busy_i);

endmodule

`default_nettype wire

// File: logic/link_ctrl.sv
/*
 * APB registers and checksum job FSM
 * Reads BASE..BASE+LEN-1, writes the byte sum at BASE+LEN
 */
`timescale 1ns/1ps
`default_nettype none

module link_ctrl (
    input  logic                   clk,
    input  logic                   rst_cpu,
    input  logic                   cen_i,
    input  mcu_link_pkg::apb_req_t apb_i,
    output mcu_link_pkg::apb_rsp_t apb_o,
    input  logic                   job_req_i,
    output logic                   job_clr_o,
    output logic                   busy_o,
    output logic                   bus_req_n_o,
    output mcu_link_pkg::mem_req_t mem_req_o,
    input  mcu_link_pkg::mem_rsp_t mem_rsp_i
);
    import mcu_link_pkg::*;

    link_state_t state;
    byte_addr_t  base_q;
    len_t        len_q;
    data8_t      result_q;
    data8_t      sum_q;
    len_t        cnt_q;
    logic        done_q;
    logic        pend_q;
    logic        apb_acc;
    logic        mapped;
    logic        last_byte;

    assign busy_o    = (state != IDLE);
    assign job_clr_o = (state == DONE);
    assign last_byte = (cnt_q == len_t'(len_q - 8'd1));

    // APB decode, zero wait states
    assign apb_acc = apb_i.psel && apb_i.penable;
    always_comb begin
        mapped       = 1'b1;
        apb_o.prdata = '0;
        case (apb_i.paddr)
            REG_BASE:   apb_o.prdata = {16'd0, base_q};
            REG_LEN:    apb_o.prdata = {24'd0, len_q};
            REG_STATUS: apb_o.prdata = {30'd0, done_q, busy_o};
            REG_RESULT: apb_o.prdata = {24'd0, result_q};
            default:    mapped = 1'b0;
        endcase
        apb_o.pready  = 1'b1;
        apb_o.pslverr = apb_acc && !mapped;
    end

    // Byte request, held by pend_q once taken
    always_comb begin
        mem_req_o.acc   = ((state == READ) || (state == WRITE)) && (pend_q || cen_i);
        mem_req_o.wr    = (state == WRITE);
        mem_req_o.wdata = sum_q;
        if (state == WRITE) begin
            mem_req_o.addr = byte_addr_t'(base_q + byte_addr_t'(len_q));
        end else begin
            mem_req_o.addr = byte_addr_t'(base_q + byte_addr_t'(cnt_q));
        end
    end

    always_ff @(posedge clk or posedge rst_cpu) begin
        if (rst_cpu) begin
            state       <= IDLE;
            base_q      <= '0;
            len_q       <= '0;
            result_q    <= '0;
            done_q      <= 1'b0;
            pend_q      <= 1'b0;
            bus_req_n_o <= 1'b1;
        end else begin
            // Register writes, config locked while busy
            if (apb_acc && apb_i.pwrite) begin
                if (apb_i.paddr == REG_BASE && !busy_o) begin
                    base_q <= apb_i.pwdata[15:0];
                end
                if (apb_i.paddr == REG_LEN && !busy_o) begin
                    len_q <= apb_i.pwdata[7:0];
                end
                if (apb_i.paddr == REG_STATUS && apb_i.pwdata[1]) begin
                    done_q <= 1'b0;
                end
            end
            if (mem_req_o.acc && !pend_q) begin
                pend_q <= 1'b1;
            end else if (mem_rsp_i.done) begin
                pend_q <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (job_req_i) begin
                        bus_req_n_o <= 1'b0;
                        state       <= REQ;
                    end
                end
                REQ:  state <= READ;
                READ: begin
                    if (mem_rsp_i.done && last_byte) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (mem_rsp_i.done) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // Status set beats a same-cycle clear
                    done_q      <= 1'b1;
                    result_q    <= sum_q;
                    bus_req_n_o <= 1'b1;
                    state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Running sum and byte index
    always_ff @(posedge clk) begin
        if (state == REQ) begin
            sum_q <= '0;
            cnt_q <= '0;
        end else if (state == READ && mem_rsp_i.done) begin
            sum_q <= data8_t'(sum_q + mem_rsp_i.rdata);
            cnt_q <= len_t'(cnt_q + 8'd1);
        end
    end

    // No RAM traffic without owning the bus
    a_acc_bus: assert property (@(posedge clk) disable iff (rst_cpu)
        mem_req_o.acc |-> !bus_req_n_o);

endmodule

`default_nettype wire

// File: logic/mcu_link_pkg.sv
/*
 * Checksum coprocessor shared types
 * Bus widths, APB register map, pacing constant, bus structs and FSM states
 */
`default_nettype none

package mcu_link_pkg;

    // Main bus addressing and data
    typedef logic [15:0] byte_addr_t;
    typedef logic [14:0] word_addr_t;
    typedef logic [7:0]  data8_t;
    typedef logic [15:0] data16_t;

    // Block length in bytes, 1 to 255
    typedef logic [7:0]  len_t;
    typedef logic [3:0]  apb_addr_t;

    // Bus accesses are paced like a slow MCU core
    localparam int CEN_PERIOD = 6;
    localparam int CEN_CNT_W  = $clog2(CEN_PERIOD);

    // APB register offsets
    localparam apb_addr_t REG_BASE   = 4'd0;
    localparam apb_addr_t REG_LEN    = 4'd4;
    localparam apb_addr_t REG_STATUS = 4'd8;
    localparam apb_addr_t REG_RESULT = 4'd12;

    // Single byte access from the controller to the lane port
    typedef struct packed {
        logic       acc;
        logic       wr;
        byte_addr_t addr;
        data8_t     wdata;
    } mem_req_t;

    // One-cycle completion with the selected read byte
    typedef struct packed {
        logic   done;
        data8_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_addr_t   paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {IDLE, REQ, READ, WRITE, DONE} link_state_t;

endpackage

`default_nettype wire

// File: logic/mcu_link_top.sv
/*
 * Checksum coprocessor top level
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_link_top (
    input  logic                     clk,
    input  logic                     rst_cpu,
    input  mcu_link_pkg::apb_req_t   apb_i,
    output mcu_link_pkg::apb_rsp_t   apb_o,
    input  logic                     dma_on_n_i,
    output logic                     bus_req_n_o,
    output mcu_link_pkg::word_addr_t ram_addr_o,
    output logic                     ram_ds_o,
    output logic                     ram_wr_o,
    output logic                     ram_acc_o,
    output mcu_link_pkg::data8_t     ram_dout_o,
    input  mcu_link_pkg::data16_t    ram_din_i,
    input  logic                     ram_ok_i
);
    import mcu_link_pkg::*;

    logic     cen;
    logic     job_req;
    logic     job_clr;
    logic     busy;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // Access pacing
    cen_divider u_cen (
        .clk     (clk),
        .rst_cpu (rst_cpu),
        .cen_o   (cen)
    );

    // Job trigger from the main CPU
    dma_edge_irq u_irq (
        .clk        (clk),
        .rst_cpu    (rst_cpu),
        .dma_on_n_i (dma_on_n_i),
        .busy_i     (busy),
        .job_clr_i  (job_clr),
        .job_req_o  (job_req)
    );

    byte_lane_port u_port (
        .clk        (clk),
        .rst_cpu    (rst_cpu),
        .req_i      (mem_req),
        .rsp_o      (mem_rsp),
        .ram_addr_o (ram_addr_o),
        .ram_ds_o   (ram_ds_o),
        .ram_wr_o   (ram_wr_o),
        .ram_acc_o  (ram_acc_o),
        .ram_dout_o (ram_dout_o),
        .ram_din_i  (ram_din_i),
        .ram_ok_i   (ram_ok_i)
    );

    link_ctrl u_ctrl (
        .clk         (clk),
        .rst_cpu     (rst_cpu),
        .cen_i       (cen),
        .apb_i       (apb_i),
        .apb_o       (apb_o),
        .job_req_i   (job_req),
        .job_clr_o   (job_clr),
        .busy_o      (busy),
        .bus_req_n_o (bus_req_n_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mcu_link_tb \
    -f build.f -o mcu_link_sim > sim.log 2>&1 &&
./obj_dir/mcu_link_sim >> sim.log 2>&1 ||
echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
